/* logic/execSettings_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath and instruction info widths
`define EXEC_DATA_W 64
`define EXEC_ADDR_W 40
`define EXEC_IMM_W 32

// architectural registers
`define EXEC_REG_COUNT 31
`define EXEC_REG_IDX_W 5
`define EXEC_IMM_CODE 31  // operand code selecting the immediate

// one quotient bit per step
`define EXEC_DIV_STEPS `EXEC_DATA_W

`endif

/* logic/execPkg.sv */
`default_nettype none
`include "execSettings_settings.svh"

package execPkg;

    typedef enum logic [2:0] {
        opNone = 3'd0,
        opAlu  = 3'd1,
        opDiv  = 3'd2
    } opType_e;

    typedef enum logic [3:0] {
        aluAdd        = 4'd0,
        aluSub        = 4'd1,
        aluAnd        = 4'd2,
        aluOr         = 4'd3,
        aluXor        = 4'd4,
        aluNot        = 4'd5,
        aluShl        = 4'd6,
        aluShrLogic   = 4'd7,
        aluShrArith   = 4'd8,
        aluLtSigned   = 4'd9,
        aluLtUnsigned = 4'd10,
        aluEqual      = 4'd11
    } aluFunc_e;

    typedef enum logic [3:0] {
        divQuotient  = 4'd0,
        divRemainder = 4'd1
    } divFunc_e;

    // one select word, read by whichever unit the op type names
    typedef union packed {
        aluFunc_e alu;
        divFunc_e div;
    } funcSel_u;

    typedef enum logic [3:0] {
        abNone          = 4'd0,
        abDecodeError   = 4'd1,
        abDivisionError = 4'd2
    } abnormal_e;

    typedef struct packed {
        logic                    isValid;
        logic [`EXEC_ADDR_W-1:0] orderAddress;
        logic [31:0]             orderCode;
        logic                    isHaveAbnormal;
        abnormal_e               abnormalCode;
    } primaryInfo_t;

    typedef struct packed {
        logic                       isValid;
        opType_e                    opType;
        funcSel_u                   funcSel;
        logic [`EXEC_REG_IDX_W-1:0] operA;
        logic [`EXEC_REG_IDX_W-1:0] operB;
        logic [`EXEC_IMM_W-1:0]     operImme;
    } operInfo_t;

    typedef logic [`EXEC_REG_COUNT-1:0][`EXEC_DATA_W-1:0] regFile_t;

endpackage

`default_nettype wire

/* logic/operandSelect.sv */
`timescale 1ns/1ps
`default_nettype none
`include "execSettings_settings.svh"

module operandSelect (
    input  wire execPkg::regFile_t   allRegValue,
    input  wire execPkg::operInfo_t  operIn,
    output logic [`EXEC_DATA_W-1:0] numA,
    output logic [`EXEC_DATA_W-1:0] numB
);

    logic [`EXEC_DATA_W-1:0] immExt;
    logic                    aIsImm;
    logic                    bIsImm;

    // immediate sign-extended to a full word
    assign immExt = {{(`EXEC_DATA_W-`EXEC_IMM_W){operIn.operImme[`EXEC_IMM_W-1]}},
                     operIn.operImme};

    assign aIsImm = (operIn.operA == `EXEC_REG_IDX_W'(`EXEC_IMM_CODE));
    assign bIsImm = (operIn.operB == `EXEC_REG_IDX_W'(`EXEC_IMM_CODE));

    always_comb begin
        if (!operIn.isValid) begin
            numA = '0;
        end else if (aIsImm) begin
            numA = '0;  // A has no immediate form
        end else begin
            numA = allRegValue[operIn.operA];
        end
    end

    always_comb begin
        if (!operIn.isValid) begin
            numB = '0;
        end else if (bIsImm) begin
            numB = immExt;
        end else begin
            numB = allRegValue[operIn.operB];
        end
    end

endmodule

`default_nettype wire

/* logic/intAlu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "execSettings_settings.svh"

module intAlu (
    input  wire [`EXEC_DATA_W-1:0] numA,
    input  wire [`EXEC_DATA_W-1:0] numB,
    input  wire execPkg::aluFunc_e func,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    error
);
    import execPkg::*;

    localparam int w = `EXEC_DATA_W;
    localparam int shiftW = $clog2(w);

    logic [shiftW-1:0] shAmt;
    logic              ltSigned;
    logic              ltUnsigned;
    logic              isEqual;

    assign shAmt = numB[shiftW-1:0];  // low bits only

    assign ltSigned = $signed(numA) < $signed(numB);
    assign ltUnsigned = numA < numB;
    assign isEqual = numA == numB;

    always_comb begin
        result = '0;
        error = 1'b0;
        case (func)
            aluAdd: begin
                result = numA + numB;
            end
            aluSub: begin
                result = numA - numB;
            end
            aluAnd: begin
                result = numA & numB;
            end
            aluOr: begin
                result = numA | numB;
            end
            aluXor: begin
                result = numA ^ numB;
            end
            aluNot: begin
                result = ~numA;  // B ignored
            end
            aluShl: begin
                result = numA << shAmt;
            end
            aluShrLogic: begin
                result = numA >> shAmt;
            end
            aluShrArith: begin
                result = $signed(numA) >>> shAmt;
            end
            // compares land in bit zero
            aluLtSigned: begin
                result = w'(ltSigned);
            end
            aluLtUnsigned: begin
                result = w'(ltUnsigned);
            end
            aluEqual: begin
                result = w'(isEqual);
            end
            default: begin
                error = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/serialDivider.sv */
`timescale 1ns/1ps
`default_nettype none
`include "execSettings_settings.svh"

module serialDivider (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     clean,
    input  wire                     start,
    input  wire [`EXEC_DATA_W-1:0]  numA,
    input  wire [`EXEC_DATA_W-1:0]  numB,
    input  wire execPkg::divFunc_e  func,
    output logic                    done,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    error
);
    import execPkg::*;

    localparam int w = `EXEC_DATA_W;
    localparam int steps = `EXEC_DIV_STEPS;
    localparam int cntW = $clog2(steps + 1);

    logic            busy;
    logic            errFlag;
    logic [cntW-1:0] count;
    logic            stepping;

    logic [w-1:0] quoReg;  // dividend shifts out as quotient shifts in
    logic [w-1:0] remReg;
    logic [w-1:0] divisorReg;
    divFunc_e     funcReg;

    logic [w:0]   shifted;
    logic [w+1:0] diff;

    assign shifted = {remReg, quoReg[w-1]};
    assign diff = {1'b0, shifted} - {2'b00, divisorReg};

    assign stepping = busy && !errFlag && (count != cntW'(steps));
    assign done = busy && (errFlag || count == cntW'(steps));
    assign error = errFlag;
    assign result = errFlag ? '0 : ((funcReg == divRemainder) ? remReg : quoReg);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy <= 1'b0;
            errFlag <= 1'b0;
            count <= '0;
        end else if (clean) begin
            busy <= 1'b0;
            errFlag <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= '0;
            // bad divisor or func finishes next cycle
            errFlag <= (numB == '0) || !(func inside {divQuotient, divRemainder});
        end else if (done) begin
            busy <= 1'b0;
        end else if (stepping) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quoReg <= numA;
            remReg <= '0;
            divisorReg <= numB;
            funcReg <= func;
        end else if (stepping) begin
            if (!diff[w+1]) begin  // no borrow, subtract fits
                remReg <= diff[w-1:0];
                quoReg <= {quoReg[w-2:0], 1'b1};
            end else begin
                remReg <= shifted[w-1:0];
                quoReg <= {quoReg[w-2:0], 1'b0};
            end
        end
    end

    // the stage must hold off new work until done
    startWhileBusy: assert property (@(posedge clk) disable iff (!rst)
        start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "execSettings_settings.svh"

module executeStage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       clean,
    input  wire                       start,
    input  wire execPkg::regFile_t    allRegValue,
    input  wire execPkg::primaryInfo_t primaryIn,
    input  wire execPkg::operInfo_t   operIn,
    output logic                      ready,
    output logic                      running,
    output logic                      isBeReady,
    output logic [`EXEC_DATA_W-1:0]   resValue,
    output execPkg::primaryInfo_t     primaryOut,
    output execPkg::operInfo_t        operOut
);
    import execPkg::*;

    logic [`EXEC_DATA_W-1:0] numA;
    logic [`EXEC_DATA_W-1:0] numB;
    logic [`EXEC_DATA_W-1:0] aluResult;
    logic                    aluError;
    logic [`EXEC_DATA_W-1:0] divResult;
    logic                    divError;
    logic                    divDone;

    logic busyReg;
    logic accept;
    logic instValid;
    logic aluStart;
    logic divStart;

    logic                    finish;
    logic                    haveError;
    abnormal_e               abCode;
    logic [`EXEC_DATA_W-1:0] unitResult;
    logic [`EXEC_DATA_W-1:0] resNext;
    primaryInfo_t            primaryNext;
    operInfo_t               operNext;

    operandSelect opSel (
        .allRegValue(allRegValue),
        .operIn(operIn),
        .numA(numA),
        .numB(numB)
    );

    intAlu alu (
        .numA(numA),
        .numB(numB),
        .func(operIn.funcSel.alu),
        .result(aluResult),
        .error(aluError)
    );

    serialDivider div (
        .clk(clk),
        .rst(rst),
        .clean(clean),
        .start(divStart),
        .numA(numA),
        .numB(numB),
        .func(operIn.funcSel.div),
        .done(divDone),
        .result(divResult),
        .error(divError)
    );

    assign ready = !busyReg;
    assign accept = start && ready;
    assign instValid = primaryIn.isValid && operIn.isValid;
    assign aluStart = accept && instValid && (operIn.opType == opAlu);
    assign divStart = accept && instValid && (operIn.opType == opDiv);

    assign running = (accept && instValid) || busyReg;
    assign isBeReady = busyReg ? divDone : (accept && instValid && finish);

    // completion and error of whichever unit owns the instruction
    always_comb begin
        finish = 1'b1;
        haveError = 1'b0;
        abCode = abDecodeError;
        unitResult = '0;
        if (busyReg) begin
            finish = divDone;
            haveError = divError;
            unitResult = divResult;
            if (operIn.funcSel.div inside {divQuotient, divRemainder}) begin
                abCode = abDivisionError;  // only a zero divisor is left
            end
        end else if (aluStart) begin
            haveError = aluError;
            unitResult = aluResult;
        end else if (divStart) begin
            finish = 1'b0;
        end else begin
            haveError = instValid && !(operIn.opType inside {opNone, opAlu, opDiv});
        end
    end

    always_comb begin
        primaryNext = '0;
        operNext = '0;
        resNext = '0;
        if (instValid) begin
            primaryNext = primaryIn;
            if (haveError) begin
                primaryNext.isHaveAbnormal = 1'b1;
                primaryNext.abnormalCode = abCode;
            end else begin
                operNext = operIn;
                resNext = unitResult;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busyReg <= 1'b0;
            primaryOut <= '0;
            operOut <= '0;
            resValue <= '0;
        end else if (clean) begin
            busyReg <= 1'b0;
            primaryOut <= '0;
            operOut <= '0;
            resValue <= '0;
        end else if (accept || busyReg) begin
            if (finish) begin
                busyReg <= 1'b0;
                primaryOut <= primaryNext;
                operOut <= operNext;
                resValue <= resNext;
            end else begin
                busyReg <= 1'b1;  // outputs invalid until the divider ends
                primaryOut <= '0;
                operOut <= '0;
            end
        end
    end

    // divider completions only arrive while the stage waits on one
    divDoneWhileBusy: assert property (@(posedge clk) disable iff (!rst)
        divDone |-> busyReg)
        else $error("divider done outside a running instruction");

    // a busy period ends only through a completion or a flush
    readyAfterDone: assert property (@(posedge clk) disable iff (!rst)
        $rose(ready) |-> $past(isBeReady) || $past(clean))
        else $error("ready rose without a completion");

endmodule

`default_nettype wire

/* tb/executeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "execSettings_settings.svh"

module executeStageTb;
    import execPkg::*;

    localparam int numRows = 25;
    localparam int divLatency = `EXEC_DIV_STEPS + 1;
    localparam int watchNs = (numRows + 3) * (`EXEC_DIV_STEPS + 10) * 4;

    typedef struct packed {
        logic                       valid;
        logic [2:0]                 opType;
        logic [3:0]                 func;
        logic [`EXEC_REG_IDX_W-1:0] codeA;
        logic [`EXEC_REG_IDX_W-1:0] codeB;
        logic [`EXEC_IMM_W-1:0]     imm;
        logic                       useRandom;
        logic [3:0]                 expAb;
    } stimRow_t;

    logic                    clk;
    logic                    rst;
    logic                    clean;
    logic                    start;
    regFile_t                allRegValue;
    primaryInfo_t            primaryIn;
    operInfo_t               operIn;
    logic                    ready;
    logic                    running;
    logic                    isBeReady;
    logic [`EXEC_DATA_W-1:0] resValue;
    primaryInfo_t            primaryOut;
    operInfo_t               operOut;

    stimRow_t    rows [numRows];
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;

    executeStage dut (
        .clk(clk),
        .rst(rst),
        .clean(clean),
        .start(start),
        .allRegValue(allRegValue),
        .primaryIn(primaryIn),
        .operIn(operIn),
        .ready(ready),
        .running(running),
        .isBeReady(isBeReady),
        .resValue(resValue),
        .primaryOut(primaryOut),
        .operOut(operOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(watchNs);
        $display("watchdog expired, run did not finish within %0d ns", watchNs);
        $display("TEST FAIL");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [`EXEC_DATA_W-1:0] randomWord(input int nBits);
        logic [`EXEC_DATA_W-1:0] word;
        word = '0;
        for (int i = 0; i < nBits; i++) begin
            word = {word[`EXEC_DATA_W-2:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return word;
    endfunction

    function automatic logic [`EXEC_DATA_W-1:0] operandValue(
        input logic [`EXEC_REG_IDX_W-1:0] code,
        input logic [`EXEC_IMM_W-1:0]     imm,
        input logic                       isB
    );
        if (code == `EXEC_REG_IDX_W'(`EXEC_IMM_CODE)) begin
            return isB ? {{(`EXEC_DATA_W-`EXEC_IMM_W){imm[`EXEC_IMM_W-1]}}, imm} : '0;
        end
        return allRegValue[code];
    endfunction

    // reference results straight from the instruction rules
    function automatic logic [`EXEC_DATA_W-1:0] modelResult(
        input logic [2:0]              opType,
        input logic [3:0]              func,
        input logic [`EXEC_DATA_W-1:0] a,
        input logic [`EXEC_DATA_W-1:0] b
    );
        logic [5:0] sh;
        sh = b[5:0];
        if (opType == opDiv) begin
            return (func == divRemainder) ? a % b : a / b;
        end
        case (func)
            aluAdd:        return a + b;
            aluSub:        return a - b;
            aluAnd:        return a & b;
            aluOr:         return a | b;
            aluXor:        return a ^ b;
            aluNot:        return ~a;
            aluShl:        return a << sh;
            aluShrLogic:   return a >> sh;
            aluShrArith:   return $signed(a) >>> sh;
            aluLtSigned:   return `EXEC_DATA_W'($signed(a) < $signed(b));
            aluLtUnsigned: return `EXEC_DATA_W'(a < b);
            aluEqual:      return `EXEC_DATA_W'(a == b);
            default:       return '0;
        endcase
    endfunction

    task automatic checkEqual(input int row, input string what,
                              input logic [127:0] got, input logic [127:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t row %0d: %s is %h, expected %h", $time, row, what, got, exp);
        end
    endtask

    task automatic fillRegs(input logic useRandom);
        for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
            if (useRandom) begin
                allRegValue[i] = randomWord(`EXEC_DATA_W);
            end else begin
                allRegValue[i] = `EXEC_DATA_W'(i) * 64'h0001_0203_0405_0607;  // reg 0 is zero
            end
        end
    endtask

    task automatic loadRows();
        rows[0]  = '{1'b1, opAlu, aluAdd, 5'd1, 5'd2, 32'h0, 1'b1, abNone};
        rows[1]  = '{1'b1, opAlu, aluSub, 5'd3, 5'd4, 32'h0, 1'b1, abNone};
        rows[2]  = '{1'b1, opAlu, aluAnd, 5'd5, 5'd6, 32'h0, 1'b1, abNone};
        rows[3]  = '{1'b1, opAlu, aluOr, 5'd7, 5'd8, 32'h0, 1'b1, abNone};
        rows[4]  = '{1'b1, opAlu, aluXor, 5'd9, 5'd10, 32'h0, 1'b1, abNone};
        rows[5]  = '{1'b1, opAlu, aluNot, 5'd11, 5'd12, 32'h0, 1'b1, abNone};
        rows[6]  = '{1'b1, opAlu, aluShl, 5'd13, 5'd14, 32'h0, 1'b1, abNone};
        rows[7]  = '{1'b1, opAlu, aluShrLogic, 5'd15, 5'd16, 32'h0, 1'b1, abNone};
        rows[8]  = '{1'b1, opAlu, aluShrArith, 5'd17, 5'd18, 32'h0, 1'b1, abNone};
        rows[9]  = '{1'b1, opAlu, aluLtSigned, 5'd19, 5'd20, 32'h0, 1'b1, abNone};
        rows[10] = '{1'b1, opAlu, aluLtUnsigned, 5'd21, 5'd22, 32'h0, 1'b1, abNone};
        rows[11] = '{1'b1, opAlu, aluEqual, 5'd23, 5'd23, 32'h0, 1'b1, abNone};
        rows[12] = '{1'b1, opAlu, aluAdd, 5'd31, 5'd31, 32'hffff_fff0, 1'b1, abNone};
        rows[13] = '{1'b1, opAlu, aluSub, 5'd2, 5'd31, 32'h0000_1234, 1'b1, abNone};
        rows[14] = '{1'b1, opDiv, divQuotient, 5'd29, 5'd31, 32'd7, 1'b0, abNone};
        rows[15] = '{1'b1, opDiv, divRemainder, 5'd29, 5'd31, 32'd7, 1'b0, abNone};
        rows[16] = '{1'b1, opDiv, divRemainder, 5'd4, 5'd5, 32'h0, 1'b1, abNone};
        rows[17] = '{1'b1, opDiv, divQuotient, 5'd30, 5'd3, 32'h0, 1'b0, abNone};
        rows[18] = '{1'b1, opDiv, divQuotient, 5'd6, 5'd0, 32'h0, 1'b0, abDivisionError};
        rows[19] = '{1'b1, opDiv, divRemainder, 5'd6, 5'd31, 32'h0, 1'b1, abDivisionError};
        rows[20] = '{1'b1, opAlu, 4'd12, 5'd1, 5'd2, 32'h0, 1'b1, abDecodeError};
        rows[21] = '{1'b1, opDiv, 4'd3, 5'd1, 5'd2, 32'h0, 1'b1, abDecodeError};
        rows[22] = '{1'b1, 3'd5, aluAdd, 5'd1, 5'd2, 32'h0, 1'b1, abDecodeError};
        rows[23] = '{1'b0, opAlu, aluAdd, 5'd1, 5'd2, 32'h0, 1'b1, abNone};
        rows[24] = '{1'b0, opDiv, divQuotient, 5'd1, 5'd2, 32'h0, 1'b1, abNone};
    endtask

    task automatic driveInst(input stimRow_t r);
        primaryIn.isValid = r.valid;
        primaryIn.orderAddress = `EXEC_ADDR_W'(randomWord(`EXEC_ADDR_W));
        primaryIn.orderCode = 32'(randomWord(32));
        primaryIn.isHaveAbnormal = 1'b0;
        primaryIn.abnormalCode = abNone;
        operIn.isValid = r.valid;
        operIn.opType = opType_e'(r.opType);
        operIn.funcSel.alu = aluFunc_e'(r.func);
        operIn.operA = r.codeA;
        operIn.operB = r.codeB;
        operIn.operImme = r.imm;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic runRow(input int idx);
        stimRow_t                r;
        logic [`EXEC_DATA_W-1:0] a;
        logic [`EXEC_DATA_W-1:0] b;
        logic [`EXEC_DATA_W-1:0] expRes;
        primaryInfo_t            expPrimary;
        operInfo_t               expOper;
        int                      edges;
        int                      pulses;
        int                      expEdges;
        r = rows[idx];
        fillRegs(r.useRandom);
        driveInst(r);
        start = 1'b1;
        a = operandValue(r.codeA, r.imm, 1'b0);
        b = operandValue(r.codeB, r.imm, 1'b1);
        #1;  // middle of the low phase
        checkEqual(idx, "running at start", 128'(running), 128'(r.valid));
        pulses = isBeReady ? 1 : 0;
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        edges = 0;
        while (!ready && edges <= divLatency + 4) begin
            checkEqual(idx, "primaryOut.isValid while busy", 128'(primaryOut.isValid), 128'(0));
            checkEqual(idx, "running while busy", 128'(running), 128'(1));
            if (isBeReady) begin
                pulses++;
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (!ready) begin
            errorCount++;
            $display("row %0d: ready never came back after %0d cycles", idx, edges);
        end
        expEdges = 0;
        if (r.valid && r.opType == opDiv) begin
            expEdges = (r.expAb == abNone) ? divLatency : 1;  // errors end at once
        end
        checkEqual(idx, "cycles to ready", 128'(edges), 128'(expEdges));
        checkEqual(idx, "isBeReady pulses", 128'(pulses), 128'(r.valid));
        expPrimary = '0;
        expOper = '0;
        expRes = '0;
        if (r.valid) begin
            expPrimary = primaryIn;
            if (r.expAb == abNone) begin
                expOper = operIn;
                expRes = modelResult(r.opType, r.func, a, b);
            end else begin
                expPrimary.isHaveAbnormal = 1'b1;
                expPrimary.abnormalCode = abnormal_e'(r.expAb);
            end
        end
        checkEqual(idx, "resValue", 128'(resValue), 128'(expRes));
        checkEqual(idx, "primaryOut", 128'(primaryOut), 128'(expPrimary));
        checkEqual(idx, "operOut", 128'(operOut), 128'(expOper));
    endtask

    task automatic cleanMidDivision();
        runRow(0);  // leaves a nonzero result for the flush to clear
        fillRegs(1'b1);
        driveInst('{1'b1, opDiv, divQuotient, 5'd1, 5'd2, 32'h0, 1'b1, abNone});
        start = 1'b1;
        @(posedge clk);
        @(negedge clk);
        start = 1'b0;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
        end
        checkEqual(numRows, "ready while dividing", 128'(ready), 128'(0));
        clean = 1'b1;
        @(posedge clk);
        @(negedge clk);
        clean = 1'b0;
        checkEqual(numRows, "ready after clean", 128'(ready), 128'(1));
        checkEqual(numRows, "running after clean", 128'(running), 128'(0));
        checkEqual(numRows, "isBeReady after clean", 128'(isBeReady), 128'(0));
        checkEqual(numRows, "primaryOut after clean", 128'(primaryOut), 128'(0));
        checkEqual(numRows, "operOut after clean", 128'(operOut), 128'(0));
        checkEqual(numRows, "resValue after clean", 128'(resValue), 128'(0));
    endtask

    initial begin
        rst = 1'b0;
        clean = 1'b0;
        start = 1'b0;
        allRegValue = '0;
        primaryIn = '0;
        operIn = '0;
        lfsrState = 32'hceed_2b4e;
        errorCount = 0;
        checkCount = 0;
        loadRows();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < numRows; i++) begin
            runRow(i);
        end
        cleanMidDivision();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/execPkg.sv
logic/operandSelect.sv
logic/intAlu.sv
logic/serialDivider.sv
logic/executeStage.sv
tb/executeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module executeStageTb -o execSim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/execSim > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log

grep -qx "TEST PASS" sim.log && exit 0 || exit 1
